/* hw/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	// datapath width and register count
	localparam int XLEN = 16;
	localparam int NREG = 16;
	localparam int RIDX = $clog2(NREG);

	typedef logic [XLEN-1:0] word_t;
	typedef logic [RIDX-1:0] reg_idx_t;

	//////////////////////////////
	// instruction set
	//////////////////////////////

	// top nibble of every instruction
	typedef enum logic [3:0] {
		OP_NOP   = 4'h0,
		OP_ADDU  = 4'h1,
		OP_SUBU  = 4'h2,
		OP_AND   = 4'h3,
		OP_OR    = 4'h4,
		OP_SLL   = 4'h5,
		OP_LI    = 4'h6,
		OP_ADDIU = 4'h7,
		OP_LW    = 4'h8,
		OP_SW    = 4'h9,
		OP_BEQZ  = 4'ha,
		OP_B     = 4'hb,
		OP_HALT  = 4'hc
	} opcode_e;

	// op rx ry rz; imm8 overlays ry and rz
	typedef struct packed {
		opcode_e  op;
		reg_idx_t rx;
		reg_idx_t ry;
		reg_idx_t rz;
	} instr_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLL,
		ALU_PASSB
	} alu_op_e;

	// memory stage wishbone state
	typedef enum logic {
		BUS_IDLE,
		BUS_WAIT
	} bus_state_e;

	//////////////////////////////
	// pipeline registers
	//////////////////////////////

	typedef struct packed {
		word_t instr;
		word_t pc_plus1;
	} if_id_t;

	// src_c is the store data source (rz of sw)
	typedef struct packed {
		alu_op_e  alu_op;
		word_t    op_a;
		word_t    op_b;
		reg_idx_t src_a;
		reg_idx_t src_b;
		reg_idx_t src_c;
		logic     use_imm;
		reg_idx_t rd;
		logic     reg_write;
		logic     load;
		logic     store;
		word_t    store_data;
		logic     halt;
	} id_ex_t;

	typedef struct packed {
		word_t    alu_result;
		word_t    store_data;
		reg_idx_t rd;
		logic     reg_write;
		logic     load;
		logic     store;
		logic     halt;
	} ex_mem_t;

	typedef struct packed {
		word_t    value;
		reg_idx_t rd;
		logic     reg_write;
	} mem_wb_t;

	// wishbone master outputs, stb follows cyc
	typedef struct packed {
		logic  cyc;
		logic  stb;
		logic  we;
		word_t adr;
		word_t dat;
	} wb_req_t;

endpackage

`default_nettype wire

/* hw/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file (
	input  wire                           clk,
	input  wire                           rst_n_i,
	input  wire  cpu_pkg::reg_idx_t       raddr_a_i,
	input  wire  cpu_pkg::reg_idx_t       raddr_b_i,
	input  wire  cpu_pkg::reg_idx_t       raddr_c_i,
	input  wire                           we_i,
	input  wire  cpu_pkg::reg_idx_t       waddr_i,
	input  wire  [cpu_pkg::XLEN-1:0]      wdata_i,
	output logic [cpu_pkg::XLEN-1:0]      rdata_a_o,
	output logic [cpu_pkg::XLEN-1:0]      rdata_b_o,
	output logic [cpu_pkg::XLEN-1:0]      rdata_c_o
);

	logic [cpu_pkg::XLEN-1:0] regs_q [cpu_pkg::NREG];

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < cpu_pkg::NREG; i++) begin
				regs_q[i] <= '0;
			end
		end else if (we_i) begin
			regs_q[waddr_i] <= wdata_i;
		end
	end

	// write-through, wb in same cycle as decode read
	assign rdata_a_o = (we_i && waddr_i == raddr_a_i) ? wdata_i : regs_q[raddr_a_i];
	assign rdata_b_o = (we_i && waddr_i == raddr_b_i) ? wdata_i : regs_q[raddr_b_i];
	assign rdata_c_o = (we_i && waddr_i == raddr_c_i) ? wdata_i : regs_q[raddr_c_i];

endmodule

`default_nettype wire

/* hw/fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
	parameter logic [cpu_pkg::XLEN-1:0] RESET_PC = '0
) (
	input  wire                           clk,
	input  wire                           rst_n_i,
	input  wire                           stall_i,
	input  wire                           freeze_i,
	input  wire                           flush_i,
	input  wire                           halt_i,
	input  wire                           branch_taken_i,
	input  wire  [cpu_pkg::XLEN-1:0]      branch_target_i,
	input  wire  [cpu_pkg::XLEN-1:0]      instr_data_i,
	output logic [cpu_pkg::XLEN-1:0]      instr_addr_o,
	output cpu_pkg::if_id_t               if_id_o
);

	logic [cpu_pkg::XLEN-1:0] pc_q;
	logic [cpu_pkg::XLEN-1:0] pc_plus1;
	cpu_pkg::if_id_t          if_id_q;

	// rom answers combinationally on the pc
	assign pc_plus1     = pc_q + 1'b1;
	assign instr_addr_o = pc_q;
	assign if_id_o      = if_id_q;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pc_q    <= RESET_PC;
			if_id_q <= '0;
		end else if (halt_i) begin
			// pc parked, only nops into decode
			if_id_q <= '0;
		end else if (!freeze_i && !stall_i) begin
			// redirect wins over sequential fetch
			pc_q <= branch_taken_i ? branch_target_i : pc_plus1;
			if (flush_i) begin
				// younger instr behind taken branch
				if_id_q <= '0;
			end else begin
				if_id_q.instr    <= instr_data_i;
				if_id_q.pc_plus1 <= pc_plus1;
			end
		end
	end

endmodule

`default_nettype wire

/* hw/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
	input  wire                           clk,
	input  wire                           rst_n_i,
	input  wire                           freeze_i,
	input  wire                           bubble_i,
	input  wire  cpu_pkg::if_id_t         if_id_i,
	input  wire  cpu_pkg::ex_mem_t        ex_mem_fwd_i,
	input  wire  [cpu_pkg::XLEN-1:0]      rdata_a_i,
	input  wire  [cpu_pkg::XLEN-1:0]      rdata_b_i,
	input  wire  [cpu_pkg::XLEN-1:0]      rdata_c_i,
	output cpu_pkg::reg_idx_t             raddr_a_o,
	output cpu_pkg::reg_idx_t             raddr_b_o,
	output cpu_pkg::reg_idx_t             raddr_c_o,
	output logic                          branch_taken_o,
	output logic [cpu_pkg::XLEN-1:0]      branch_target_o,
	output logic                          branch_cond_o,
	output cpu_pkg::reg_idx_t             src_a_o,
	output cpu_pkg::reg_idx_t             src_b_o,
	output cpu_pkg::reg_idx_t             src_c_o,
	output cpu_pkg::id_ex_t               id_ex_o
);

	cpu_pkg::instr_t          ins;
	logic [7:0]               imm8;
	logic [cpu_pkg::XLEN-1:0] imm_sext;
	logic [cpu_pkg::XLEN-1:0] imm_zext;
	logic [cpu_pkg::XLEN-1:0] rx_val;
	cpu_pkg::id_ex_t          id_ex_d;
	cpu_pkg::id_ex_t          id_ex_q;

	assign ins      = cpu_pkg::instr_t'(if_id_i.instr);
	assign imm8     = {ins.ry, ins.rz};
	assign imm_sext = {{(cpu_pkg::XLEN-8){imm8[7]}}, imm8};
	assign imm_zext = {{(cpu_pkg::XLEN-8){1'b0}}, imm8};

	// all three fields read every cycle
	assign raddr_a_o = ins.rx;
	assign raddr_b_o = ins.ry;
	assign raddr_c_o = ins.rz;
	assign src_a_o   = ins.rx;
	assign src_b_o   = ins.ry;
	assign src_c_o   = ins.rz;

	//////////////////////////////
	// branch resolution
	//////////////////////////////

	// alu result bypass, mem/wb comes through the regfile
	assign rx_val = (ex_mem_fwd_i.reg_write && !ex_mem_fwd_i.load &&
		ex_mem_fwd_i.rd == ins.rx) ? ex_mem_fwd_i.alu_result : rdata_a_i;

	assign branch_cond_o   = (ins.op == cpu_pkg::OP_BEQZ);
	assign branch_taken_o  = (ins.op == cpu_pkg::OP_B) || (branch_cond_o && rx_val == '0);
	assign branch_target_o = if_id_i.pc_plus1 + imm_sext;

	//////////////////////////////
	// control decode
	//////////////////////////////

	always_comb begin
		id_ex_d            = '0;
		id_ex_d.op_a       = rdata_a_i;
		id_ex_d.op_b       = rdata_b_i;
		id_ex_d.store_data = rdata_c_i;
		id_ex_d.src_a      = ins.rx;
		id_ex_d.src_b      = ins.ry;
		id_ex_d.src_c      = ins.rz;
		case (ins.op)
			cpu_pkg::OP_ADDU,
			cpu_pkg::OP_SUBU,
			cpu_pkg::OP_AND,
			cpu_pkg::OP_OR,
			cpu_pkg::OP_SLL: begin
				id_ex_d.rd        = ins.rz;
				id_ex_d.reg_write = 1'b1;
			end
			cpu_pkg::OP_LI,
			cpu_pkg::OP_ADDIU: begin
				// rx is both source and dest here
				id_ex_d.rd        = ins.rx;
				id_ex_d.reg_write = 1'b1;
				id_ex_d.use_imm   = 1'b1;
				id_ex_d.op_b      = (ins.op == cpu_pkg::OP_LI) ? imm_zext : imm_sext;
			end
			cpu_pkg::OP_LW: begin
				id_ex_d.rd        = ins.rz;
				id_ex_d.reg_write = 1'b1;
				id_ex_d.load      = 1'b1;
			end
			cpu_pkg::OP_SW: id_ex_d.store = 1'b1;
			cpu_pkg::OP_HALT: id_ex_d.halt = 1'b1;
			default: ;
		endcase
		// address calc and addiu stay on add
		case (ins.op)
			cpu_pkg::OP_SUBU: id_ex_d.alu_op = cpu_pkg::ALU_SUB;
			cpu_pkg::OP_AND: id_ex_d.alu_op = cpu_pkg::ALU_AND;
			cpu_pkg::OP_OR: id_ex_d.alu_op = cpu_pkg::ALU_OR;
			cpu_pkg::OP_SLL: id_ex_d.alu_op = cpu_pkg::ALU_SLL;
			cpu_pkg::OP_LI: id_ex_d.alu_op = cpu_pkg::ALU_PASSB;
			default: id_ex_d.alu_op = cpu_pkg::ALU_ADD;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			id_ex_q <= '0;
		end else if (!freeze_i) begin
			if (bubble_i) begin
				id_ex_q <= '0;
			end else begin
				id_ex_q <= id_ex_d;
			end
		end
	end

	assign id_ex_o = id_ex_q;

endmodule

`default_nettype wire

/* hw/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
	input  wire                           clk,
	input  wire                           rst_n_i,
	input  wire                           freeze_i,
	input  wire  cpu_pkg::id_ex_t         id_ex_i,
	input  wire  cpu_pkg::ex_mem_t        ex_mem_fwd_i,
	input  wire  cpu_pkg::mem_wb_t        mem_wb_fwd_i,
	output cpu_pkg::ex_mem_t              ex_mem_o
);

	logic [cpu_pkg::XLEN-1:0] opnd_a;
	logic [cpu_pkg::XLEN-1:0] fwd_b;
	logic [cpu_pkg::XLEN-1:0] opnd_b;
	logic [cpu_pkg::XLEN-1:0] store_val;
	logic [cpu_pkg::XLEN-1:0] result;
	cpu_pkg::ex_mem_t         ex_mem_q;

	// nearest producer first; loads in ex/mem never reach here
	function automatic logic [cpu_pkg::XLEN-1:0] fwd(
		input cpu_pkg::reg_idx_t        src,
		input logic [cpu_pkg::XLEN-1:0] reg_val,
		input cpu_pkg::ex_mem_t         exm,
		input cpu_pkg::mem_wb_t         mwb
	);
		if (exm.reg_write && !exm.load && exm.rd == src) begin
			return exm.alu_result;
		end
		if (mwb.reg_write && mwb.rd == src) begin
			return mwb.value;
		end
		return reg_val;
	endfunction

	assign opnd_a    = fwd(id_ex_i.src_a, id_ex_i.op_a, ex_mem_fwd_i, mem_wb_fwd_i);
	assign fwd_b     = fwd(id_ex_i.src_b, id_ex_i.op_b, ex_mem_fwd_i, mem_wb_fwd_i);
	assign store_val = fwd(id_ex_i.src_c, id_ex_i.store_data, ex_mem_fwd_i, mem_wb_fwd_i);
	// immediate is final already
	assign opnd_b    = id_ex_i.use_imm ? id_ex_i.op_b : fwd_b;

	//////////////////////////////
	// alu
	//////////////////////////////

	always_comb begin
		case (id_ex_i.alu_op)
			cpu_pkg::ALU_ADD: result = opnd_a + opnd_b;
			cpu_pkg::ALU_SUB: result = opnd_a - opnd_b;
			cpu_pkg::ALU_AND: result = opnd_a & opnd_b;
			cpu_pkg::ALU_OR: result = opnd_a | opnd_b;
			cpu_pkg::ALU_SLL: result = opnd_a << opnd_b[3:0];
			cpu_pkg::ALU_PASSB: result = opnd_b;
			default: result = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ex_mem_q <= '0;
		end else if (!freeze_i) begin
			ex_mem_q.alu_result <= result;
			ex_mem_q.store_data <= store_val;
			ex_mem_q.rd         <= id_ex_i.rd;
			ex_mem_q.reg_write  <= id_ex_i.reg_write;
			ex_mem_q.load       <= id_ex_i.load;
			ex_mem_q.store      <= id_ex_i.store;
			ex_mem_q.halt       <= id_ex_i.halt;
		end
	end

	assign ex_mem_o = ex_mem_q;

endmodule

`default_nettype wire

/* hw/hazard_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
	input  wire  cpu_pkg::reg_idx_t       src_a_i,
	input  wire  cpu_pkg::reg_idx_t       src_b_i,
	input  wire  cpu_pkg::reg_idx_t       src_c_i,
	input  wire                           branch_cond_i,
	input  wire  cpu_pkg::id_ex_t         id_ex_i,
	input  wire  cpu_pkg::ex_mem_t        ex_mem_i,
	input  wire                           branch_taken_i,
	input  wire                           bus_busy_i,
	output logic                          stall_if_o,
	output logic                          flush_if_o,
	output logic                          bubble_id_o,
	output logic                          freeze_o
);

	logic load_use;
	logic branch_dep;
	logic stall;

	// load in id/ex feeding any field decode reads
	assign load_use = id_ex_i.load && (id_ex_i.rd == src_a_i ||
		id_ex_i.rd == src_b_i || id_ex_i.rd == src_c_i);

	// beqz compares in decode
	// only ex/mem alu results are bypassed there, so wait for id/ex writers and ex/mem loads
	assign branch_dep = branch_cond_i &&
		((id_ex_i.reg_write && id_ex_i.rd == src_a_i) ||
		(ex_mem_i.load && ex_mem_i.rd == src_a_i));

	assign stall = load_use || branch_dep;

	// hold pc and if/id, send a nop down to execute
	assign stall_if_o  = stall;
	assign bubble_id_o = stall;

	// redirect only once the branch operand is final
	assign flush_if_o = branch_taken_i && !stall;

	// whole pipeline waits on the bus
	assign freeze_o = bus_busy_i;

endmodule

`default_nettype wire

/* hw/memory_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module memory_stage (
	input  wire                           clk,
	input  wire                           rst_n_i,
	input  wire  cpu_pkg::ex_mem_t        ex_mem_i,
	input  wire                           ack_i,
	input  wire  [cpu_pkg::XLEN-1:0]      dat_i,
	output cpu_pkg::wb_req_t              wb_o,
	output logic                          bus_busy_o,
	output cpu_pkg::mem_wb_t              mem_wb_o,
	output logic                          halted_o
);

	cpu_pkg::bus_state_e      state_q;
	logic                     cyc_q;
	logic                     we_q;
	logic [cpu_pkg::XLEN-1:0] adr_q;
	logic [cpu_pkg::XLEN-1:0] dat_q;
	logic                     halted_q;
	logic                     mem_req;
	cpu_pkg::mem_wb_t         mem_wb_q;

	// nothing reaches the bus once halted
	assign mem_req = (ex_mem_i.load || ex_mem_i.store) && !halted_q;

	// issue cycle plus every wait cycle, released in the ack cycle
	assign bus_busy_o = (state_q == cpu_pkg::BUS_IDLE) ? mem_req : !ack_i;

	//////////////////////////////
	// wishbone classic master
	//////////////////////////////

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= cpu_pkg::BUS_IDLE;
			cyc_q   <= 1'b0;
			we_q    <= 1'b0;
		end else begin
			case (state_q)
				cpu_pkg::BUS_IDLE: if (mem_req) begin
					state_q <= cpu_pkg::BUS_WAIT;
					cyc_q   <= 1'b1;
					we_q    <= ex_mem_i.store;
				end
				cpu_pkg::BUS_WAIT: if (ack_i) begin
					// cyc/stb drop the cycle after ack
					state_q <= cpu_pkg::BUS_IDLE;
					cyc_q   <= 1'b0;
					we_q    <= 1'b0;
				end
				default: state_q <= cpu_pkg::BUS_IDLE;
			endcase
		end
	end

	// address and data captured at issue, held until ack
	always_ff @(posedge clk) begin
		if (state_q == cpu_pkg::BUS_IDLE && mem_req) begin
			adr_q <= ex_mem_i.alu_result;
			dat_q <= ex_mem_i.store_data;
		end
	end

	assign wb_o = '{cyc: cyc_q, stb: cyc_q, we: we_q, adr: adr_q, dat: dat_q};

	//////////////////////////////
	// mem/wb and halt
	//////////////////////////////

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			mem_wb_q <= '0;
			halted_q <= 1'b0;
		end else if (!bus_busy_o) begin
			// load data valid only in the ack cycle
			mem_wb_q.value     <= ex_mem_i.load ? dat_i : ex_mem_i.alu_result;
			mem_wb_q.rd        <= ex_mem_i.rd;
			mem_wb_q.reg_write <= ex_mem_i.reg_write && !halted_q;
			halted_q           <= halted_q || ex_mem_i.halt;
		end
	end

	assign mem_wb_o = mem_wb_q;
	assign halted_o = halted_q;

endmodule

`default_nettype wire

/* hw/cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
	parameter logic [cpu_pkg::XLEN-1:0] RESET_PC = '0
) (
	input  wire                           clk,
	input  wire                           rst_n_i,
	input  wire  [cpu_pkg::XLEN-1:0]      instr_data_i,
	input  wire                           ack_i,
	input  wire  [cpu_pkg::XLEN-1:0]      dat_i,
	output logic [cpu_pkg::XLEN-1:0]      instr_addr_o,
	output logic                          cyc_o,
	output logic                          stb_o,
	output logic                          we_o,
	output logic [cpu_pkg::XLEN-1:0]      adr_o,
	output logic [cpu_pkg::XLEN-1:0]      dat_o,
	output logic                          halted_o
);

	// pipeline registers
	cpu_pkg::if_id_t          if_id;
	cpu_pkg::id_ex_t          id_ex;
	cpu_pkg::ex_mem_t         ex_mem;
	cpu_pkg::mem_wb_t         mem_wb;

	// regfile ports
	cpu_pkg::reg_idx_t        raddr_a;
	cpu_pkg::reg_idx_t        raddr_b;
	cpu_pkg::reg_idx_t        raddr_c;
	logic [cpu_pkg::XLEN-1:0] rdata_a;
	logic [cpu_pkg::XLEN-1:0] rdata_b;
	logic [cpu_pkg::XLEN-1:0] rdata_c;

	// branch and hazard control
	logic                     branch_taken;
	logic [cpu_pkg::XLEN-1:0] branch_target;
	logic                     branch_cond;
	cpu_pkg::reg_idx_t        src_a;
	cpu_pkg::reg_idx_t        src_b;
	cpu_pkg::reg_idx_t        src_c;
	logic                     stall_if;
	logic                     flush_if;
	logic                     bubble_id;
	logic                     freeze;
	logic                     bus_busy;
	cpu_pkg::wb_req_t         wb_req;

	//////////////////////////////
	// stages
	//////////////////////////////

	fetch_stage #(
		.RESET_PC(RESET_PC)
	) u_fetch (
		.clk             (clk),
		.rst_n_i         (rst_n_i),
		.stall_i         (stall_if),
		.freeze_i        (freeze),
		.flush_i         (flush_if),
		.halt_i          (halted_o),
		.branch_taken_i  (branch_taken),
		.branch_target_i (branch_target),
		.instr_data_i    (instr_data_i),
		.instr_addr_o    (instr_addr_o),
		.if_id_o         (if_id)
	);

	decode_stage u_decode (
		.clk             (clk),
		.rst_n_i         (rst_n_i),
		.freeze_i        (freeze),
		.bubble_i        (bubble_id),
		.if_id_i         (if_id),
		.ex_mem_fwd_i    (ex_mem),
		.rdata_a_i       (rdata_a),
		.rdata_b_i       (rdata_b),
		.rdata_c_i       (rdata_c),
		.raddr_a_o       (raddr_a),
		.raddr_b_o       (raddr_b),
		.raddr_c_o       (raddr_c),
		.branch_taken_o  (branch_taken),
		.branch_target_o (branch_target),
		.branch_cond_o   (branch_cond),
		.src_a_o         (src_a),
		.src_b_o         (src_b),
		.src_c_o         (src_c),
		.id_ex_o         (id_ex)
	);

	// written from mem/wb
	register_file u_regfile (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.raddr_a_i (raddr_a),
		.raddr_b_i (raddr_b),
		.raddr_c_i (raddr_c),
		.we_i      (mem_wb.reg_write),
		.waddr_i   (mem_wb.rd),
		.wdata_i   (mem_wb.value),
		.rdata_a_o (rdata_a),
		.rdata_b_o (rdata_b),
		.rdata_c_o (rdata_c)
	);

	execute_stage u_execute (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.freeze_i     (freeze),
		.id_ex_i      (id_ex),
		.ex_mem_fwd_i (ex_mem),
		.mem_wb_fwd_i (mem_wb),
		.ex_mem_o     (ex_mem)
	);

	hazard_unit u_hazard (
		.src_a_i        (src_a),
		.src_b_i        (src_b),
		.src_c_i        (src_c),
		.branch_cond_i  (branch_cond),
		.id_ex_i        (id_ex),
		.ex_mem_i       (ex_mem),
		.branch_taken_i (branch_taken),
		.bus_busy_i     (bus_busy),
		.stall_if_o     (stall_if),
		.flush_if_o     (flush_if),
		.bubble_id_o    (bubble_id),
		.freeze_o       (freeze)
	);

	memory_stage u_memory (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.ex_mem_i   (ex_mem),
		.ack_i      (ack_i),
		.dat_i      (dat_i),
		.wb_o       (wb_req),
		.bus_busy_o (bus_busy),
		.mem_wb_o   (mem_wb),
		.halted_o   (halted_o)
	);

	// flatten the wishbone request
	assign cyc_o = wb_req.cyc;
	assign stb_o = wb_req.stb;
	assign we_o  = wb_req.we;
	assign adr_o = wb_req.adr;
	assign dat_o = wb_req.dat;

endmodule

`default_nettype wire

/* sim/cpu_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_properties (
	input wire                      clk,
	input wire                      rst_n_i,
	input wire                      cyc_i,
	input wire                      stb_i,
	input wire                      we_i,
	input wire [cpu_pkg::XLEN-1:0]  adr_i,
	input wire [cpu_pkg::XLEN-1:0]  wdat_i,
	input wire                      ack_i,
	input wire                      halted_i
);

	//////////////////////////////
	// wishbone classic rules
	//////////////////////////////

	// reset holds bus and halt low
	reset_quiet: assert property (@(posedge clk)
		!rst_n_i |-> (!cyc_i && !stb_i && !we_i && !halted_i))
		else $error("bus or halt active while reset is held");

	// ack closes the cycle on the next edge
	ack_closes: assert property (@(posedge clk) disable iff (!rst_n_i)
		(stb_i && ack_i) |=> (!cyc_i && !stb_i))
		else $error("cyc or stb still high the cycle after ack");

	// request frozen until the slave acks
	req_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
		(stb_i && !ack_i) |=> (stb_i && $stable(adr_i) && $stable(we_i) && $stable(wdat_i)))
		else $error("bus request changed before ack");

	// halted core never touches the bus
	quiet_halt: assert property (@(posedge clk) disable iff (!rst_n_i)
		halted_i |-> (!cyc_i && !stb_i))
		else $error("bus cycle while halted");

endmodule

bind cpu_top cpu_properties u_props (
	.clk      (clk),
	.rst_n_i  (rst_n_i),
	.cyc_i    (cyc_o),
	.stb_i    (stb_o),
	.we_i     (we_o),
	.adr_i    (adr_o),
	.wdat_i   (dat_o),
	.ack_i    (ack_i),
	.halted_i (halted_o)
);

`default_nettype wire

/* sim/tb_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;

	localparam int ROM_WORDS = 64;
	localparam int MEM_WORDS = 256;
	localparam int TIMEOUT   = 2000;

	logic            clk;
	logic            rst_n;
	cpu_pkg::word_t  instr_addr;
	cpu_pkg::word_t  instr_data;
	logic            ack;
	cpu_pkg::word_t  dat_rd;
	logic            cyc;
	logic            stb;
	logic            we;
	cpu_pkg::word_t  adr;
	cpu_pkg::word_t  dat_wr;
	logic            halted;

	integer          seed;
	cpu_pkg::word_t  rom [ROM_WORDS];
	string           rom_tag [ROM_WORDS];
	cpu_pkg::word_t  mem [MEM_WORDS];
	int              n_instr;

	// expected stores, program order
	cpu_pkg::word_t  exp_adr [$];
	cpu_pkg::word_t  exp_dat [$];
	string           exp_tag [$];

	cpu_top #(
		.RESET_PC('0)
	) dut (
		.clk          (clk),
		.rst_n_i      (rst_n),
		.instr_data_i (instr_data),
		.ack_i        (ack),
		.dat_i        (dat_rd),
		.instr_addr_o (instr_addr),
		.cyc_o        (cyc),
		.stb_o        (stb),
		.we_o         (we),
		.adr_o        (adr),
		.dat_o        (dat_wr),
		.halted_o     (halted)
	);

	// rom answers in the same cycle
	assign instr_data = rom[instr_addr[5:0]];

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	//////////////////////////////
	// failure reporting
	//////////////////////////////

	task automatic stop_failed();
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string test, input cpu_pkg::word_t expected,
		input cpu_pkg::word_t actual);
		$display("FAIL %s expected %h actual %h", test, expected, actual);
		stop_failed();
	endtask

	task automatic abort_run(input string why);
		$display("ERROR %s", why);
		stop_failed();
	endtask

	//////////////////////////////
	// program and reference model
	//////////////////////////////

	// op rx ry rz
	function automatic cpu_pkg::word_t rrr_word(cpu_pkg::opcode_e op, int rx, int ry, int rz);
		return {op, 4'(rx), 4'(ry), 4'(rz)};
	endfunction

	// op rx imm8
	function automatic cpu_pkg::word_t imm_word(cpu_pkg::opcode_e op, int rx, logic [7:0] imm);
		return {op, 4'(rx), imm};
	endfunction

	task automatic emit(input cpu_pkg::word_t w, input string tag);
		rom[n_instr]     = w;
		rom_tag[n_instr] = tag;
		n_instr++;
	endtask

	task automatic fill_memory();
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = cpu_pkg::word_t'($random(seed));
		end
	endtask

	task automatic build_program();
		logic [7:0] imm_a;
		logic [7:0] imm_b;
		logic [7:0] imm_c;
		imm_a = 8'($random(seed));
		imm_b = 8'($random(seed));
		imm_c = 8'($random(seed));
		for (int i = 0; i < ROM_WORDS; i++) begin
			rom[i]     = '0;
			rom_tag[i] = "nop";
		end
		n_instr = 0;
		// each op needs the one before, ex/mem and mem/wb paths
		emit(imm_word(cpu_pkg::OP_LI, 1, imm_a), "alu_chain");
		emit(imm_word(cpu_pkg::OP_LI, 2, imm_b), "alu_chain");
		emit(rrr_word(cpu_pkg::OP_ADDU, 1, 2, 3), "alu_chain");
		emit(rrr_word(cpu_pkg::OP_SUBU, 3, 1, 4), "alu_chain");
		emit(rrr_word(cpu_pkg::OP_AND, 4, 3, 5), "alu_chain");
		emit(rrr_word(cpu_pkg::OP_OR, 5, 2, 6), "alu_chain");
		emit(rrr_word(cpu_pkg::OP_SLL, 6, 4, 7), "alu_chain");
		emit(imm_word(cpu_pkg::OP_ADDIU, 7, imm_c), "alu_chain");
		emit(imm_word(cpu_pkg::OP_LI, 8, 8'h40), "alu_chain");
		emit(rrr_word(cpu_pkg::OP_SW, 8, 0, 3), "alu_chain");
		for (int r = 4; r <= 7; r++) begin
			emit(imm_word(cpu_pkg::OP_ADDIU, 8, 8'h01), "alu_chain");
			emit(rrr_word(cpu_pkg::OP_SW, 8, 0, r), "alu_chain");
		end
		// load then immediate user
		emit(imm_word(cpu_pkg::OP_LI, 10, 8'h10), "load_use");
		emit(rrr_word(cpu_pkg::OP_LW, 10, 0, 11), "load_use");
		emit(rrr_word(cpu_pkg::OP_ADDU, 11, 1, 12), "load_use");
		emit(imm_word(cpu_pkg::OP_ADDIU, 8, 8'h01), "load_use");
		emit(rrr_word(cpu_pkg::OP_SW, 8, 0, 12), "load_use");
		// load straight into store data
		emit(imm_word(cpu_pkg::OP_LI, 9, 8'h20), "load_store");
		emit(imm_word(cpu_pkg::OP_ADDIU, 8, 8'h01), "load_store");
		emit(rrr_word(cpu_pkg::OP_LW, 9, 0, 13), "load_store");
		emit(rrr_word(cpu_pkg::OP_SW, 8, 0, 13), "load_store");
		// taken beqz on a just computed zero
		emit(rrr_word(cpu_pkg::OP_SUBU, 1, 1, 13), "beqz_taken");
		emit(imm_word(cpu_pkg::OP_BEQZ, 13, 8'h01), "beqz_taken");
		emit(rrr_word(cpu_pkg::OP_SW, 8, 0, 1), "beqz_taken");
		emit(imm_word(cpu_pkg::OP_ADDIU, 8, 8'h01), "beqz_taken");
		emit(rrr_word(cpu_pkg::OP_SW, 8, 0, 2), "beqz_taken");
		// not taken, falls through
		emit(imm_word(cpu_pkg::OP_LI, 14, 8'h01), "beqz_not_taken");
		emit(imm_word(cpu_pkg::OP_BEQZ, 14, 8'h01), "beqz_not_taken");
		emit(imm_word(cpu_pkg::OP_ADDIU, 8, 8'h01), "beqz_not_taken");
		emit(rrr_word(cpu_pkg::OP_SW, 8, 0, 3), "beqz_not_taken");
		// unconditional, skips two stores
		emit(imm_word(cpu_pkg::OP_B, 0, 8'h02), "branch");
		emit(rrr_word(cpu_pkg::OP_SW, 8, 0, 4), "branch");
		emit(rrr_word(cpu_pkg::OP_SW, 8, 0, 5), "branch");
		emit(imm_word(cpu_pkg::OP_ADDIU, 8, 8'h01), "branch");
		emit(rrr_word(cpu_pkg::OP_SW, 8, 0, 6), "branch");
		// store behind halt must stay off the bus
		emit(imm_word(cpu_pkg::OP_HALT, 0, 8'h00), "halt");
		emit(rrr_word(cpu_pkg::OP_SW, 8, 0, 7), "halt");
	endtask

	// in-order interpreter, ISA rules only
	task automatic run_model();
		cpu_pkg::word_t regs [cpu_pkg::NREG];
		cpu_pkg::word_t shadow [MEM_WORDS];
		cpu_pkg::word_t w;
		cpu_pkg::word_t pc;
		cpu_pkg::word_t sext;
		cpu_pkg::word_t ea;
		logic [3:0]     rx;
		logic [3:0]     ry;
		logic [3:0]     rz;
		int             cur;
		for (int i = 0; i < cpu_pkg::NREG; i++) begin
			regs[i] = '0;
		end
		for (int i = 0; i < MEM_WORDS; i++) begin
			shadow[i] = mem[i];
		end
		pc = '0;
		for (int steps = 0; steps < 1000; steps++) begin
			cur  = int'(pc[5:0]);
			w    = rom[cur];
			rx   = w[11:8];
			ry   = w[7:4];
			rz   = w[3:0];
			sext = {{8{w[7]}}, w[7:0]};
			ea   = regs[rx] + regs[ry];
			if (w[15:12] == cpu_pkg::OP_HALT) begin
				return;
			end
			pc = pc + 1'b1;
			case (cpu_pkg::opcode_e'(w[15:12]))
				cpu_pkg::OP_ADDU: regs[rz] = regs[rx] + regs[ry];
				cpu_pkg::OP_SUBU: regs[rz] = regs[rx] - regs[ry];
				cpu_pkg::OP_AND: regs[rz] = regs[rx] & regs[ry];
				cpu_pkg::OP_OR: regs[rz] = regs[rx] | regs[ry];
				cpu_pkg::OP_SLL: regs[rz] = regs[rx] << regs[ry][3:0];
				cpu_pkg::OP_LI: regs[rx] = {8'h00, w[7:0]};
				cpu_pkg::OP_ADDIU: regs[rx] = regs[rx] + sext;
				cpu_pkg::OP_LW: regs[rz] = shadow[ea[7:0]];
				cpu_pkg::OP_SW: begin
					shadow[ea[7:0]] = regs[rz];
					exp_adr.push_back(ea);
					exp_dat.push_back(regs[rz]);
					exp_tag.push_back(rom_tag[cur]);
				end
				// offsets are relative to pc plus one
				cpu_pkg::OP_BEQZ: if (regs[rx] == '0) pc = pc + sext;
				cpu_pkg::OP_B: pc = pc + sext;
				default: ;
			endcase
		end
		abort_run("reference model never reached HALT");
	endtask

	//////////////////////////////
	// wishbone slave
	//////////////////////////////

	task automatic check_store();
		cpu_pkg::word_t e_adr;
		cpu_pkg::word_t e_dat;
		string          tag;
		if (exp_adr.size() == 0) begin
			abort_run($sformatf("store to address %h after the last expected store", adr));
		end else begin
			e_adr = exp_adr.pop_front();
			e_dat = exp_dat.pop_front();
			tag   = exp_tag.pop_front();
			assert (adr == e_adr) else report_mismatch({tag, " store address"}, e_adr, adr);
			assert (dat_wr == e_dat) else report_mismatch({tag, " store data"}, e_dat, dat_wr);
		end
	endtask

	task automatic serve_access();
		if (we) begin
			check_store();
			mem[adr[7:0]] = dat_wr;
		end else begin
			dat_rd <= mem[adr[7:0]];
		end
	endtask

	// 0..3 wait cycles per access, ack held one cycle
	initial begin : wb_slave
		int   waits;
		logic active;
		active = 1'b0;
		waits  = 0;
		forever begin
			@(posedge clk);
			if (ack) begin
				ack <= 1'b0;
			end else if (rst_n && cyc && stb) begin
				if (!active) begin
					active = 1'b1;
					waits  = int'($unsigned($random(seed)) % 4);
				end
				if (waits == 0) begin
					active = 1'b0;
					ack <= 1'b1;
					serve_access();
				end else begin
					waits--;
				end
			end
		end
	end

	//////////////////////////////
	// main sequence
	//////////////////////////////

	initial begin : main_seq
		int cycles;
		seed   = 56956;
		rst_n  = 1'b0;
		ack    = 1'b0;
		dat_rd = '0;
		// memory and immediates drawn before reset
		fill_memory();
		build_program();
		run_model();
		repeat (8) @(posedge clk);
		// reset still held at this edge
		assert (instr_addr == '0) else report_mismatch("reset pc", '0, instr_addr);
		assert (!cyc && !stb && !we) else abort_run("bus strobes active during reset");
		assert (!halted) else abort_run("halted_o high during reset");
		rst_n <= 1'b1;
		cycles = 0;
		while (!halted && cycles < TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		if (!halted) begin
			abort_run("halted_o never rose within the timeout");
		end else begin
			// quiet bus after halt
			repeat (20) begin
				@(posedge clk);
				assert (!cyc && !stb) else abort_run("a bus cycle started after halt");
			end
			if (exp_adr.size() == 0) begin
				$display("TEST OK");
				$finish;
			end else begin
				abort_run($sformatf("%0d expected stores never appeared", exp_adr.size()));
			end
		end
	end

endmodule

`default_nettype wire

/* project.f */
hw/cpu_pkg.sv
hw/register_file.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/hazard_unit.sv
hw/memory_stage.sv
hw/cpu_top.sv
sim/cpu_properties.sv
sim/tb_cpu.sv

/* run_sim.sh */
#!/bin/sh
# build and run the cpu testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu \
	--Mdir obj_dir -o tb_cpu -f project.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_cpu > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
	echo "simulation reported failure"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
echo "simulation passed"
exit 0
